// ==== include/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// first instruction sits one word above address 0
`define RESET_VECTOR 32'h0000_0004
`define RAM_WORDS    256

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_ADDIU   6'h09
`define OP_LW      6'h23
`define OP_SW      6'h2b

// funct codes under OP_SPECIAL
`define FN_SLL  6'h00
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a
`define FN_SLTU 6'h2b

`endif

// ==== verilog/mips_pkg.sv ====
`include "mips_defines.svh"

package mips_pkg;

    localparam int RAM_AW = $clog2(`RAM_WORDS); // word index width into the RAM

    typedef logic [31:0]       word_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [RAM_AW-1:0] ram_idx_t;

    // ********************
    // master side of the four-phase link

    // held stable by the master while req is high
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

    typedef struct packed {
        word_t rdata; // valid while ack is high
    } bus_rsp_t;

    // ********************
    // state machines

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_WB,
        ST_HALT
    } core_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,
        ARB_ACK
    } arb_state_t;

endpackage

// ==== verilog/avalon_ram.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module avalon_ram
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    address,
    input  logic     read,
    input  logic     write,
    input  word_t    writedata,
    input  logic [3:0] byteenable,
    output word_t    readdata,
    output logic     waitrequest,
    input  logic     load_en,
    input  ram_idx_t load_addr,
    input  word_t    load_data
);

    word_t    mem [`RAM_WORDS];
    ram_idx_t idx;
    logic     rd_ready_q; // read data has been fetched and sits on readdata

    assign idx = address[RAM_AW+1:2]; // byte address to word index

    // a read stalls for its first cycle only, writes never stall
    assign waitrequest = read && !rd_ready_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ready_q <= 1'b0;
        end else begin
            rd_ready_q <= read && !rd_ready_q;
        end
    end

    always_ff @(posedge clk) begin
        readdata <= mem[idx];
        if (load_en) begin
            mem[load_addr] <= load_data; // testbench program load wins over the bus
        end else if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[idx][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n) !(read && write))
        else $error("avalon_ram: read and write asserted together");

endmodule

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fetch_req,
    input  bus_req_t   fetch_bus_req,
    output logic       fetch_ack,
    output bus_rsp_t   fetch_bus_rsp,
    input  logic       lsu_req,
    input  bus_req_t   lsu_bus_req,
    output logic       lsu_ack,
    output bus_rsp_t   lsu_bus_rsp,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata,
    input  logic       waitrequest
);

    arb_state_t state_q;
    logic       owner_lsu_q; // 1 while the grant belongs to load/store
    logic       owner_req;
    bus_req_t   cur_q;
    word_t      rdata_q;

    assign owner_req = owner_lsu_q ? lsu_req : fetch_req;

    // ********************
    // grant and transfer sequencing

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ARB_IDLE;
            owner_lsu_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (lsu_req || fetch_req) begin
                        state_q     <= ARB_BUSY;
                        owner_lsu_q <= lsu_req; // load/store wins a tie
                    end
                end
                ARB_BUSY: if (!waitrequest) state_q <= ARB_ACK;
                ARB_ACK:  if (!owner_req) state_q <= ARB_IDLE; // master has seen ack
                default:  state_q <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ARB_IDLE) begin
            cur_q <= lsu_req ? lsu_bus_req : fetch_bus_req;
        end
        if (state_q == ARB_BUSY && !waitrequest && !cur_q.we) begin
            rdata_q <= readdata;
        end
    end

    assign address    = cur_q.addr;
    assign writedata  = cur_q.wdata;
    assign read       = (state_q == ARB_BUSY) && !cur_q.we;
    assign write      = (state_q == ARB_BUSY) && cur_q.we;
    assign byteenable = 4'hf; // whole words only

    assign fetch_ack     = (state_q == ARB_ACK) && !owner_lsu_q;
    assign lsu_ack       = (state_q == ARB_ACK) && owner_lsu_q;
    assign fetch_bus_rsp = '{rdata: rdata_q};
    assign lsu_bus_rsp   = '{rdata: rdata_q};

    // an ack only ever answers the master that still holds its req
    a_fetch_ack_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fetch_ack) |-> fetch_req)
        else $error("bus_arbiter: fetch ack raised without a fetch request");

    a_lsu_ack_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(lsu_ack) |-> lsu_req)
        else $error("bus_arbiter: lsu ack raised without an lsu request");

    a_fetch_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (fetch_req && !fetch_ack) ##1 (fetch_req && !fetch_ack) |-> $stable(fetch_bus_req))
        else $error("bus_arbiter: fetch request changed while pending");

    a_lsu_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (lsu_req && !lsu_ack) ##1 (lsu_req && !lsu_ack) |-> $stable(lsu_bus_req))
        else $error("bus_arbiter: lsu request changed while pending");

endmodule

// ==== verilog/mips_fetch.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_fetch
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     run,
    input  logic     instr_take,
    input  logic     redirect,
    input  word_t    redirect_pc,
    output logic     instr_valid,
    output word_t    instr,
    output logic     fetch_req,
    output bus_req_t fetch_bus_req,
    input  logic     fetch_ack,
    input  bus_rsp_t fetch_bus_rsp
);

    word_t pc_q;        // address of the word being or about to be fetched
    word_t buf_q;
    word_t redir_pc_q;
    logic  buf_valid_q;
    logic  req_q;
    logic  redir_pend_q; // jump target waits for the delay slot to land
    logic  issue;
    logic  capture;

    assign capture = req_q && fetch_ack;
    // start only once ack from the previous word is gone
    assign issue   = run && !req_q && !fetch_ack && (!buf_valid_q || instr_take);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q         <= `RESET_VECTOR;
            req_q        <= 1'b0;
            buf_valid_q  <= 1'b0;
            redir_pend_q <= 1'b0;
        end else begin
            if (issue) req_q <= 1'b1;
            else if (capture) req_q <= 1'b0;

            if (capture) buf_valid_q <= 1'b1;
            else if (instr_take) buf_valid_q <= 1'b0;

            // the word landing now is the delay slot, so the stream turns here
            if (capture) begin
                if (redirect) pc_q <= redirect_pc;
                else if (redir_pend_q) pc_q <= redir_pc_q;
                else pc_q <= pc_q + 32'd4;
                redir_pend_q <= 1'b0;
            end else if (redirect) begin
                redir_pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) buf_q <= fetch_bus_rsp.rdata;
        if (redirect) redir_pc_q <= redirect_pc;
    end

    assign fetch_req     = req_q;
    assign fetch_bus_req = '{addr: pc_q, wdata: '0, we: 1'b0};
    assign instr_valid   = buf_valid_q;
    assign instr         = buf_q;

endmodule

// ==== verilog/mips_lsu.sv ====
`timescale 1ns/1ns

module mips_lsu
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     mem_start,
    input  word_t    mem_addr,
    input  word_t    mem_wdata,
    input  logic     mem_we,
    output logic     mem_done,
    output word_t    mem_rdata,
    output logic     lsu_req,
    output bus_req_t lsu_bus_req,
    input  logic     lsu_ack,
    input  bus_rsp_t lsu_bus_rsp
);

    logic     busy_q; // covers the whole handshake, until ack is low again
    logic     req_q;
    logic     done_q;
    bus_req_t breq_q;
    word_t    rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= req_q && lsu_ack;
            if (mem_start) begin
                busy_q <= 1'b1;
                req_q  <= 1'b1;
            end else begin
                if (req_q && lsu_ack) req_q <= 1'b0;
                if (busy_q && !req_q && !lsu_ack) busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) breq_q <= '{addr: mem_addr, wdata: mem_wdata, we: mem_we};
        if (req_q && lsu_ack) rdata_q <= lsu_bus_rsp.rdata;
    end

    assign lsu_req     = req_q;
    assign lsu_bus_req = breq_q;
    assign mem_done    = done_q;
    assign mem_rdata   = rdata_q;

    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n) mem_start |-> !busy_q)
        else $error("mips_lsu: mem_start while a transfer is still running");

endmodule

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  instr_valid,
    input  word_t instr,
    output logic  instr_take,
    output logic  redirect,
    output word_t redirect_pc,
    output logic  run,
    output logic  mem_start,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    input  logic  mem_done,
    input  word_t mem_rdata,
    output logic  active,
    output word_t register_v0
);

    core_state_t state_q, state_d, retire_st;
    word_t       ir_q;
    word_t       regs [32];
    logic        halt_pend_q; // jr to 0 seen, stop after its delay slot

    logic [5:0]  op, fn;
    logic [4:0]  shamt;
    reg_idx_t    rs, rt, rd, alu_dst, rf_idx;
    word_t       simm, rs_val, rt_val, alu_res, rf_data;
    logic        alu_we, is_jr, is_lw, is_sw, rf_we;

    assign op     = ir_q[31:26];
    assign rs     = ir_q[25:21];
    assign rt     = ir_q[20:16];
    assign rd     = ir_q[15:11];
    assign shamt  = ir_q[10:6];
    assign fn     = ir_q[5:0];
    assign simm   = {{16{ir_q[15]}}, ir_q[15:0]};
    assign rs_val = (rs == '0) ? '0 : regs[rs]; // $zero is hardwired
    assign rt_val = (rt == '0) ? '0 : regs[rt];

    // ********************
    // decode and ALU
    always_comb begin
        alu_res = '0;
        alu_we  = 1'b0;
        alu_dst = rd;
        is_jr   = 1'b0;
        is_lw   = 1'b0;
        is_sw   = 1'b0;
        case (op)
            `OP_SPECIAL: begin
                alu_we = 1'b1;
                case (fn)
                    `FN_SLL:  alu_res = rt_val << shamt;
                    `FN_ADDU: alu_res = rs_val + rt_val;
                    `FN_SUBU: alu_res = rs_val - rt_val;
                    `FN_AND:  alu_res = rs_val & rt_val;
                    `FN_OR:   alu_res = rs_val | rt_val;
                    `FN_SLT:  alu_res = word_t'($signed(rs_val) < $signed(rt_val));
                    `FN_SLTU: alu_res = word_t'(rs_val < rt_val);
                    `FN_JR: begin
                        alu_we = 1'b0;
                        is_jr  = 1'b1;
                    end
                    default:  alu_we = 1'b0; // unknown funct runs as a nop
                endcase
            end
            `OP_ADDIU: begin
                alu_we  = 1'b1;
                alu_dst = rt;
                alu_res = rs_val + simm;
            end
            `OP_LW:  is_lw = 1'b1;
            `OP_SW:  is_sw = 1'b1;
            default: alu_we = 1'b0;
        endcase
    end

    // ********************
    // control FSM
    assign retire_st = halt_pend_q ? ST_HALT : ST_FETCH;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  state_d = ST_FETCH;
            ST_FETCH: if (instr_valid) state_d = ST_EXEC;
            ST_EXEC:  state_d = (is_lw || is_sw) ? ST_MEM : retire_st;
            ST_MEM:   if (mem_done) state_d = is_lw ? ST_WB : retire_st;
            ST_WB:    state_d = retire_st;
            default:  state_d = ST_HALT;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ST_IDLE;
            halt_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (redirect && redirect_pc == '0) halt_pend_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_take) ir_q <= instr;
    end

    // register file, load data lands in ST_WB
    assign rf_we   = (state_q == ST_EXEC && alu_we) || state_q == ST_WB;
    assign rf_idx  = (state_q == ST_WB) ? rt : alu_dst;
    assign rf_data = (state_q == ST_WB) ? mem_rdata : alu_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (rf_we && rf_idx != '0) begin
            regs[rf_idx] <= rf_data;
        end
    end

    assign instr_take  = (state_q == ST_FETCH) && instr_valid;
    assign redirect    = (state_q == ST_EXEC) && is_jr;
    assign redirect_pc = rs_val;
    assign mem_start   = (state_q == ST_EXEC) && (is_lw || is_sw);
    assign mem_addr    = rs_val + simm;
    assign mem_wdata   = rt_val;
    assign mem_we      = is_sw;
    assign run         = (state_q != ST_HALT); // lets fetch prefetch from reset release on
    assign active      = (state_q != ST_IDLE) && (state_q != ST_HALT);
    assign register_v0 = regs[2];

endmodule

// ==== verilog/cpu_system.sv ====
`timescale 1ns/1ns

module cpu_system
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load_en,
    input  ram_idx_t load_addr,
    input  word_t    load_data,
    output logic     active,
    output word_t    register_v0
);

    // core to fetch and lsu
    logic       instr_valid, instr_take, redirect, run;
    word_t      instr, redirect_pc;
    logic       mem_start, mem_we, mem_done;
    word_t      mem_addr, mem_wdata, mem_rdata;

    // masters to arbiter
    logic       fetch_req, fetch_ack, lsu_req, lsu_ack;
    bus_req_t   fetch_bus_req, lsu_bus_req;
    bus_rsp_t   fetch_bus_rsp, lsu_bus_rsp;

    // ********************
    // Avalon port
    word_t      address, writedata, readdata;
    logic       read, write, waitrequest;
    logic [3:0] byteenable;

    mips_core core_i (
        .clk, .arst_n, .instr_valid, .instr, .instr_take, .redirect, .redirect_pc, .run,
        .mem_start, .mem_addr, .mem_wdata, .mem_we, .mem_done, .mem_rdata,
        .active, .register_v0
    );

    mips_fetch fetch_i (
        .clk, .arst_n, .run, .instr_take, .redirect, .redirect_pc, .instr_valid, .instr,
        .fetch_req, .fetch_bus_req, .fetch_ack, .fetch_bus_rsp
    );

    mips_lsu lsu_i (
        .clk, .arst_n, .mem_start, .mem_addr, .mem_wdata, .mem_we, .mem_done, .mem_rdata,
        .lsu_req, .lsu_bus_req, .lsu_ack, .lsu_bus_rsp
    );

    bus_arbiter arb_i (
        .clk, .arst_n, .fetch_req, .fetch_bus_req, .fetch_ack, .fetch_bus_rsp,
        .lsu_req, .lsu_bus_req, .lsu_ack, .lsu_bus_rsp,
        .address, .read, .write, .writedata, .byteenable, .readdata, .waitrequest
    );

    avalon_ram ram_i (
        .clk, .arst_n, .address, .read, .write, .writedata, .byteenable,
        .readdata, .waitrequest, .load_en, .load_addr, .load_data
    );

endmodule

// ==== test/cpu_system_tb.sv ====
`timescale 1ns/1ns
`include "mips_defines.svh"

module cpu_system_tb
    import mips_pkg::*;
();

    localparam int N_PROGS = 42; // 2 directed, 30 ALU only, 10 load/store
    localparam int CLK_NS  = 100;

    logic     clk;
    logic     arst_n;
    logic     load_en;
    ram_idx_t load_addr;
    word_t    load_data;
    logic     active;
    word_t    register_v0;

    word_t    model_mem [`RAM_WORDS]; // mirror of what the RAM holds
    word_t    prog [$];                // program image starting at the reset vector
    int       errors = 0;
    int       checks = 0;

    cpu_system cpu_system_i (
        .clk, .arst_n, .load_en, .load_addr, .load_data, .active, .register_v0
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ********************
    // instruction encoding and random program pieces

    function automatic word_t enc_r(reg_idx_t rs, rt, rd, logic [4:0] sa, logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_idx_t rs, rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // destination register is drawn from lo..7
    function automatic word_t rand_alu(int unsigned lo);
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [5:0] fn;
        rs = reg_idx_t'($urandom % 8);
        rt = reg_idx_t'($urandom % 8);
        rd = reg_idx_t'(lo + $urandom % (8 - lo));
        case ($urandom % 8)
            0: return enc_i(`OP_ADDIU, rs, rd, 16'($urandom));
            1: return enc_r(5'd0, rt, rd, 5'($urandom), `FN_SLL);
            2: fn = `FN_ADDU;
            3: fn = `FN_SUBU;
            4: fn = `FN_AND;
            5: fn = `FN_OR;
            6: fn = `FN_SLT;
            default: fn = `FN_SLTU;
        endcase
        return enc_r(rs, rt, rd, 5'd0, fn);
    endfunction

    function automatic word_t rand_mem();
        logic [15:0] off;
        off = 16'(4 * ($urandom % 8)); // eight shared slots so loads hit earlier stores
        case ($urandom % 3)
            0: return enc_i(`OP_SW, 5'd1, reg_idx_t'($urandom % 8), off);
            1: return enc_i(`OP_LW, 5'd1, reg_idx_t'(2 + $urandom % 6), off);
            default: return rand_alu(2); // $1 keeps the data base address
        endcase
    endfunction

    task automatic finish_prog(input word_t slot);
        prog.push_back(enc_r(5'd0, 5'd0, 5'd0, 5'd0, `FN_JR)); // jr $0 stops the core
        prog.push_back(slot);
        prog.push_back(enc_i(`OP_ADDIU, 5'd0, 5'd2, 16'h7ead)); // past the delay slot
    endtask

    // ********************
    // instruction-level reference model

    task automatic run_model(output word_t v0);
        word_t    r [32];
        word_t    pc, ir, a, b, ea, res, target;
        reg_idx_t dst;
        logic     wr, slot_next, in_slot, done;
        for (int i = 0; i < 32; i++) r[i] = '0;
        pc        = `RESET_VECTOR;
        target    = '0;
        res       = '0;
        slot_next = 1'b0;
        done      = 1'b0;
        for (int n = 0; n < 200 && !done; n++) begin
            ir        = model_mem[pc[9:2]];
            a         = r[ir[25:21]];
            b         = r[ir[20:16]];
            ea        = a + {{16{ir[15]}}, ir[15:0]};
            dst       = ir[20:16];
            wr        = 1'b1;
            in_slot   = slot_next;
            slot_next = 1'b0;
            pc        = pc + 32'd4;
            case (ir[31:26])
                `OP_ADDIU: res = ea;
                `OP_LW:    res = model_mem[ea[9:2]];
                `OP_SW: begin
                    model_mem[ea[9:2]] = b;
                    wr = 1'b0;
                end
                `OP_SPECIAL: begin
                    dst = ir[15:11];
                    case (ir[5:0])
                        `FN_SLL:  res = b << ir[10:6];
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        `FN_OR:   res = a | b;
                        `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                        `FN_JR: begin
                            wr        = 1'b0;
                            slot_next = 1'b1; // next instruction is the delay slot
                            target    = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) r[dst] = res;
            if (in_slot) begin
                done = (target == '0);
                pc   = target;
            end
        end
        v0 = r[2];
    endtask

    // ********************
    // loading and running one program

    task automatic load_word(input ram_idx_t idx, input word_t data);
        @(negedge clk);
        checks++;
        if (active) begin
            $display("Error at %0t: active is high while reset is asserted", $time);
            errors++;
        end
        load_en        = 1'b1;
        load_addr      = idx;
        load_data      = data;
        model_mem[idx] = data;
    endtask

    task automatic run_prog(input string name);
        word_t expect_v0;
        @(negedge clk);
        arst_n = 1'b0;
        foreach (prog[i]) load_word(ram_idx_t'(i + 1), prog[i]);
        run_model(expect_v0);
        @(negedge clk);
        load_en = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        checks++;
        if (!active) begin
            $display("Error at %0t: %s program, active did not rise after reset", $time, name);
            errors++;
        end
        while (active) @(negedge clk);
        checks++;
        if (register_v0 !== expect_v0) begin
            $display("Mismatch at %0t: %s program, v0 = %h, expected %h",
                     $time, name, register_v0, expect_v0);
            errors++;
        end
        repeat (8) begin
            @(negedge clk);
            checks++;
            if (active) begin
                $display("Error at %0t: %s program, active rose again after halt", $time, name);
                errors++;
            end
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(92));
        for (int i = 0; i < `RAM_WORDS; i++) begin
            load_word(ram_idx_t'(i), {8'(i), ~8'(i), 8'(i * 37), 8'(i) ^ 8'ha5});
        end

        prog.delete();
        prog.push_back(enc_i(`OP_ADDIU, 5'd0, 5'd8, 16'd5));
        prog.push_back(enc_i(`OP_ADDIU, 5'd0, 5'd9, 16'hfffd)); // -3
        prog.push_back(enc_r(5'd8, 5'd9, 5'd3, 5'd0, `FN_SLTU));
        prog.push_back(enc_r(5'd8, 5'd9, 5'd2, 5'd0, `FN_SLT)); // signed 5 < -3 is false
        finish_prog(enc_r(5'd3, 5'd3, 5'd4, 5'd0, `FN_ADDU));
        run_prog("slt");

        prog.delete();
        prog.push_back(enc_i(`OP_ADDIU, 5'd0, 5'd2, 16'd5));
        finish_prog(enc_i(`OP_ADDIU, 5'd0, 5'd2, 16'd7)); // the slot write has to land
        run_prog("delay slot");

        repeat (30) begin
            prog.delete();
            repeat (8 + $urandom % 13) prog.push_back(rand_alu(1));
            finish_prog(rand_alu(1));
            run_prog("alu");
        end

        repeat (10) begin
            prog.delete();
            prog.push_back(enc_i(`OP_ADDIU, 5'd0, 5'd1, 16'h0200)); // data words 128 and up
            repeat (10 + $urandom % 8) prog.push_back(rand_mem());
            prog.push_back(enc_i(`OP_LW, 5'd1, 5'd2, 16'(4 * ($urandom % 8))));
            finish_prog(rand_alu(3));
            run_prog("load/store");
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized for 40 instructions of 12 cycles per program
    initial begin
        #(N_PROGS * 40 * 12 * CLK_NS);
        $display("Error at %0t: the processor never halted in the time allowed", $time);
        $display("%0d checks, %0d errors", checks, errors + 1);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
verilog/mips_pkg.sv
verilog/avalon_ram.sv
verilog/bus_arbiter.sv
verilog/mips_fetch.sv
verilog/mips_lsu.sv
verilog/mips_core.sv
verilog/cpu_system.sv
test/cpu_system_tb.sv

// ==== Bender.yml ====
package:
  name: mips_multicycle

export_include_dirs:
  - include

sources:
  - verilog/mips_pkg.sv
  - verilog/avalon_ram.sv
  - verilog/bus_arbiter.sv
  - verilog/mips_fetch.sv
  - verilog/mips_lsu.sv
  - verilog/mips_core.sv
  - verilog/cpu_system.sv
  - target: test
    files:
      - test/cpu_system_tb.sv
